/* verilog/rename_pkg.sv */
// rename package: sizes, opcode, instruction union and records shared by rename and ROB
`default_nettype none

package rename_pkg;

    // register file and reorder buffer sizes
    localparam int NUM_AREG = 32;
    localparam int NUM_PREG = 64;
    // ROB_SIZE <= NUM_PREG - NUM_AREG keeps the free list from running dry
    localparam int ROB_SIZE = 16;

    localparam int AREG_W    = $clog2(NUM_AREG);
    localparam int PREG_W    = $clog2(NUM_PREG);
    localparam int ROB_IDX_W = $clog2(ROB_SIZE);

    // register-register arithmetic opcode
    localparam logic [6:0] OPCODE_OP = 7'b0110011;

    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // R-type layout, rs2 is a real source
    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } r_view_t;

    // I-type layout, the rs2 bits belong to the immediate
    typedef struct packed {
        logic [11:0] imm;
        areg_t       rs1;
        logic [2:0]  funct3;
        areg_t       rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_t;

    // one reorder-buffer slot
    typedef struct packed {
        areg_t areg;
        preg_t new_preg;
        preg_t old_preg;
    } rob_entry_t;

    // rename result handed out one cycle after dispatch
    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    dest_preg;
        preg_t    src1_preg;
        preg_t    src2_preg;
        logic     src2_used;
    } rename_result_t;

    // commit record, free_en low for areg zero
    typedef struct packed {
        areg_t areg;
        preg_t new_preg;
        preg_t freed_preg;
        logic  free_en;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/free_list.sv */
// free list: circular queue of physical registers, popped at dispatch, pushed at retire
`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  alloc,
    output preg_t      alloc_preg,
    input  wire logic  push,
    input  wire preg_t push_preg,
    output logic       empty
);

    // queue storage and pointers, NUM_PREG is a power of two so pointers wrap
    preg_t            slots [NUM_PREG];
    preg_t            head;
    preg_t            tail;
    logic [PREG_W:0]  count;

    // head entry is always on display, consumed only on alloc
    assign alloc_preg = slots[head];
    assign empty      = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // initial pool holds NUM_AREG upward in ascending order
            // slots past the pool are dead until pushed
            for (int i = 0; i < NUM_PREG; i++) begin
                slots[i] <= preg_t'(NUM_AREG + i);
            end
            head  <= '0;
            tail  <= preg_t'(NUM_PREG - NUM_AREG);
            count <= (PREG_W + 1)'(NUM_PREG - NUM_AREG);
        end else begin
            // freed register goes behind everything already queued
            if (push) begin
                slots[tail] <= push_preg;
                tail        <= tail + 1'b1;
            end
            if (alloc) begin
                head <= head + 1'b1;
            end
            // occupancy follows push and pop together
            unique case ({alloc, push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/map_table.sv */
// map table: speculative architectural-to-physical map, looked up and updated at dispatch
`default_nettype none

module map_table
    import rename_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire inst_t inst,
    input  wire logic  map_write,
    input  wire preg_t new_preg,
    output preg_t      src1_preg,
    output preg_t      src2_preg,
    output logic       src2_used,
    output preg_t      old_preg
);

    // one physical tag per architectural register
    preg_t mapping [NUM_AREG];

    always_comb begin
        // rs1 and rd sit at the same bits in both views
        src1_preg = mapping[inst.i_view.rs1];
        old_preg  = mapping[inst.i_view.rd];

        // only R-type reads rs2, otherwise those bits are immediate
        src2_used = (inst.r_view.opcode == OPCODE_OP);
        if (src2_used) begin
            src2_preg = mapping[inst.r_view.rs2];
        end else begin
            src2_preg = '0;
        end
    end

    // lookups above see the table before this update
    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map out of reset
            for (int i = 0; i < NUM_AREG; i++) begin
                mapping[i] <= preg_t'(i);
            end
        end else if (map_write) begin
            // map_write is never raised for rd zero, entry 0 stays at preg 0
            mapping[inst.i_view.rd] <= new_preg;
        end
    end

endmodule

`default_nettype wire

/* verilog/rob_entry.sv */
// rob entry: one reorder-buffer slot with a valid bit and its record
`default_nettype none

module rob_entry
    import rename_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       write,
    input  wire rob_entry_t write_data,
    input  wire logic       release_en,
    output logic            valid,
    output rob_entry_t      data
);

    // slot occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end else if (release_en) begin
            valid <= 1'b0;
        end
    end

    // payload only changes on write
    always_ff @(posedge clock) begin
        if (write) begin
            data <= write_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/rob_dispatch.sv */
// rob dispatch: tail pointer, occupancy, full/empty and the registered rename result
`default_nettype none

module rob_dispatch
    import rename_pkg::*;
(
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          dispatch,
    input  wire inst_t         inst,
    input  wire logic          retire_accept,
    input  wire preg_t         free_preg,
    input  wire preg_t         src1_preg,
    input  wire preg_t         src2_preg,
    input  wire logic          src2_used,
    input  wire preg_t         old_preg,
    output logic               alloc,
    output logic               map_write,
    output logic [ROB_SIZE-1:0] entry_write,
    output rob_entry_t         entry_data,
    output logic               full,
    output logic               empty,
    output logic               rename_valid,
    output rename_result_t     rename
);

    rob_idx_t             tail;
    logic [ROB_IDX_W:0]   count;
    logic                 accept;
    logic                 rd_zero;

    // flags come straight off the registered count
    assign full  = (int'(count) == ROB_SIZE);
    assign empty = (count == '0);

    assign accept  = dispatch & ~full;
    assign rd_zero = (inst.r_view.rd == '0);

    // x0 never takes a register from the free list or the map
    assign alloc     = accept & ~rd_zero;
    assign map_write = accept & ~rd_zero;

    always_comb begin
        // one-hot write strobe toward the tail slot
        entry_write       = '0;
        entry_write[tail] = accept;

        entry_data.areg = inst.r_view.rd;
        if (rd_zero) begin
            entry_data.new_preg = '0;
            entry_data.old_preg = '0;
        end else begin
            entry_data.new_preg = free_preg;
            entry_data.old_preg = old_preg;
        end
    end

    // tail and occupancy, ROB_SIZE is a power of two so the tail wraps
    always_ff @(posedge clock) begin
        if (reset) begin
            tail         <= '0;
            count        <= '0;
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= accept;
            if (accept) begin
                tail <= tail + 1'b1;
            end
            unique case ({accept, retire_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // rename payload, qualified by rename_valid
    always_ff @(posedge clock) begin
        if (accept) begin
            rename.rob_idx   <= tail;
            rename.dest_preg <= entry_data.new_preg;
            rename.src1_preg <= src1_preg;
            rename.src2_preg <= src2_preg;
            rename.src2_used <= src2_used;
        end
    end

endmodule

`default_nettype wire

/* verilog/rob_retire.sv */
// rob retire: head pointer, head-entry select and the registered commit record
`default_nettype none

module rob_retire
    import rename_pkg::*;
(
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        retire,
    input  wire logic                        empty,
    input  wire rob_entry_t [ROB_SIZE-1:0]   entry_data,
    output logic [ROB_SIZE-1:0]              release_en,
    output logic                             retire_accept,
    output logic                             push,
    output preg_t                            push_preg,
    output logic                             commit_valid,
    output commit_t                          commit
);

    rob_idx_t   head;
    rob_entry_t head_entry;
    logic       areg_nonzero;

    // oldest slot
    assign head_entry   = entry_data[head];
    assign areg_nonzero = (head_entry.areg != '0);

    assign retire_accept = retire & ~empty;

    // told goes back to the free list, skipped for x0
    assign push      = retire_accept & areg_nonzero;
    assign push_preg = head_entry.old_preg;

    always_comb begin
        release_en       = '0;
        release_en[head] = retire_accept;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire_accept;
            // wraps with the power-of-two ring
            if (retire_accept) begin
                head <= head + 1'b1;
            end
        end
    end

    // commit payload for the architectural map
    always_ff @(posedge clock) begin
        if (retire_accept) begin
            commit.areg       <= head_entry.areg;
            commit.new_preg   <= head_entry.new_preg;
            commit.freed_preg <= head_entry.old_preg;
            commit.free_en    <= areg_nonzero;
        end
    end

endmodule

`default_nettype wire

/* verilog/rename_rob_top.sv */
// rename and ROB top: map table, free list, dispatch, entry ring and retire
`default_nettype none

module rename_rob_top
    import rename_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     dispatch,
    input  wire inst_t    inst,
    input  wire logic     retire,
    output logic          rename_valid,
    output rename_result_t rename,
    output logic          commit_valid,
    output commit_t       commit,
    output logic          full,
    output logic          empty
);

    // rename side
    logic                      alloc;
    logic                      map_write;
    preg_t                     free_preg;
    logic                      free_empty;
    preg_t                     src1_preg;
    preg_t                     src2_preg;
    logic                      src2_used;
    preg_t                     old_preg;

    // entry ring
    logic [ROB_SIZE-1:0]       entry_write;
    rob_entry_t                alloc_entry;
    logic [ROB_SIZE-1:0]       entry_release;
    logic [ROB_SIZE-1:0]       entry_valid;
    rob_entry_t [ROB_SIZE-1:0] slot_data;

    // retire side
    logic                      retire_accept;
    logic                      push;
    preg_t                     push_preg;

    map_table u_map_table (
        .clock     (clock),
        .reset     (reset),
        .inst      (inst),
        .map_write (map_write),
        .new_preg  (free_preg),
        .src1_preg (src1_preg),
        .src2_preg (src2_preg),
        .src2_used (src2_used),
        .old_preg  (old_preg)
    );

    free_list u_free_list (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_preg (free_preg),
        .push       (push),
        .push_preg  (push_preg),
        .empty      (free_empty)
    );

    rob_dispatch u_rob_dispatch (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .inst          (inst),
        .retire_accept (retire_accept),
        .free_preg     (free_preg),
        .src1_preg     (src1_preg),
        .src2_preg     (src2_preg),
        .src2_used     (src2_used),
        .old_preg      (old_preg),
        .alloc         (alloc),
        .map_write     (map_write),
        .entry_write   (entry_write),
        .entry_data    (alloc_entry),
        .full          (full),
        .empty         (empty),
        .rename_valid  (rename_valid),
        .rename        (rename)
    );

    // every slot sees the same record, only the tail slot is strobed
    for (genvar i = 0; i < ROB_SIZE; i++) begin : g_entry
        rob_entry u_rob_entry (
            .clock      (clock),
            .reset      (reset),
            .write      (entry_write[i]),
            .write_data (alloc_entry),
            .release_en (entry_release[i]),
            .valid      (entry_valid[i]),
            .data       (slot_data[i])
        );
    end

    rob_retire u_rob_retire (
        .clock         (clock),
        .reset         (reset),
        .retire        (retire),
        .empty         (empty),
        .entry_data    (slot_data),
        .release_en    (entry_release),
        .retire_accept (retire_accept),
        .push          (push),
        .push_preg     (push_preg),
        .commit_valid  (commit_valid),
        .commit        (commit)
    );

endmodule

`default_nettype wire

/* tb/rename_rob_checker.sv */
// rename/ROB checker: bound assertions on occupancy flags, free-list safety and commit timing
`default_nettype none

module rename_rob_checker
    import rename_pkg::*;
(
    input wire logic                clock,
    input wire logic                reset,
    input wire logic                full,
    input wire logic                empty,
    input wire logic                alloc,
    input wire logic                free_empty,
    input wire logic                retire,
    input wire logic                commit_valid,
    input wire logic [ROB_SIZE-1:0] entry_valid
);

    // failed assertions, read by the testbench summary
    int fail_count = 0;

    // both flags at once means the occupancy count is corrupt
    flags_exclusive: assert property (@(posedge clock) disable iff (reset) !(full && empty))
        else begin
            $error("ROB full and empty are high in the same cycle");
            fail_count++;
        end

    // ROB_SIZE headroom should keep the pool from running dry
    alloc_has_preg: assert property (@(posedge clock) disable iff (reset) alloc |-> !free_empty)
        else begin
            $error("free list popped while empty");
            fail_count++;
        end

    // commit is the registered echo of an accepted retire
    commit_follows_retire: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> $past(retire && !empty))
        else begin
            $error("commit_valid without an accepted retire the cycle before");
            fail_count++;
        end

    // slot valid bits agree with the occupancy flags
    empty_slots_clear: assert property (@(posedge clock) disable iff (reset)
        empty |-> (entry_valid == '0))
        else begin
            $error("ROB empty while a slot is still valid");
            fail_count++;
        end

    full_slots_set: assert property (@(posedge clock) disable iff (reset)
        full |-> (&entry_valid))
        else begin
            $error("ROB full while a slot is not valid");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb/rename_rob_tb.sv */
// rename/ROB testbench: random dispatch and retire against a queue-based reference model
`default_nettype none

module rename_rob_tb
    import rename_pkg::*;
;

    localparam int CLOCK_PERIOD = 10;
    // sum of the per-test cycle budgets below, plus flush
    localparam int TEST_CYCLES  = 12 + 200 + 100 + 400 + 24 + 24 + 8 + 60 + 24 + 2;
    localparam int WATCHDOG     = TEST_CYCLES * 10 * CLOCK_PERIOD;

    logic           clock;
    logic           reset;
    logic           dispatch;
    inst_t          inst;
    logic           retire;
    logic           rename_valid;
    rename_result_t rename;
    logic           commit_valid;
    commit_t        commit;
    logic           full;
    logic           empty;

    int seed = 62275;

    // reference model state
    rob_entry_t rob_q[$];
    preg_t      free_q[$];
    preg_t      map_m [NUM_AREG];
    rob_idx_t   model_tail;

    // expectations for the cycle after the last drive
    logic           exp_rename_valid;
    rename_result_t exp_rename;
    logic           exp_commit_valid;
    commit_t        exp_commit;

    int checks;
    int errors;
    int test_errors;
    int test_num;

    rename_rob_top dut (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .inst         (inst),
        .retire       (retire),
        .rename_valid (rename_valid),
        .rename       (rename),
        .commit_valid (commit_valid),
        .commit       (commit),
        .full         (full),
        .empty        (empty)
    );

    bind rename_rob_top rename_rob_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .full         (full),
        .empty        (empty),
        .alloc        (alloc),
        .free_empty   (free_empty),
        .retire       (retire),
        .commit_valid (commit_valid),
        .entry_valid  (entry_valid)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // run limit
    initial begin
        #(WATCHDOG);
        $display("timeout: run did not finish within %0d time units", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    function automatic logic chance(int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    // half R-type, rd forced to zero at the given rate
    function automatic inst_t rand_inst(int zero_pct);
        inst_t i;
        i = inst_t'($random(seed));
        if (chance(50)) begin
            i.r_view.opcode = OPCODE_OP;
        end else begin
            i.i_view.opcode = 7'($random(seed));
            if (i.i_view.opcode == OPCODE_OP) begin
                i.i_view.opcode = 7'b0010011;
            end
        end
        if (chance(zero_pct)) begin
            i.r_view.rd = '0;
        end else if (i.r_view.rd == '0) begin
            i.r_view.rd = areg_t'(1);
        end
        return i;
    endfunction

    task automatic note_failure(string what);
        errors++;
        test_errors++;
        $display("%s", what);
    endtask

    task automatic compare_rename(rename_result_t exp, rename_result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR rename expected %h actual %h", exp, act);
        end
    endtask

    task automatic compare_commit(commit_t exp, commit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR commit expected %h actual %h", exp, act);
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // outputs registered at the last rising edge
    task automatic check_outputs();
        checks += 2;
        if (rename_valid !== exp_rename_valid) begin
            note_failure(exp_rename_valid ? "rename_valid missing after an accepted dispatch"
                                          : "rename_valid pulsed without an accepted dispatch");
        end else if (exp_rename_valid) begin
            compare_rename(exp_rename, rename);
        end
        if (commit_valid !== exp_commit_valid) begin
            note_failure(exp_commit_valid ? "commit_valid missing after an accepted retire"
                                          : "commit_valid pulsed without an accepted retire");
        end else if (exp_commit_valid) begin
            compare_commit(exp_commit, commit);
        end
        compare_flag("full", rob_q.size() == ROB_SIZE, full);
        compare_flag("empty", rob_q.size() == 0, empty);
    endtask

    // one clock: drive new strobes, check the previous ones, advance the model
    task automatic step(input logic d, input inst_t i, input logic r);
        rob_entry_t     e;
        rob_entry_t     head;
        rename_result_t res;
        commit_t        c;
        logic           acc_d;
        logic           acc_r;
        @(posedge clock);
        dispatch <= d;
        inst     <= i;
        retire   <= r;
        // this edge registered the previous strobes
        @(negedge clock);
        check_outputs();
        acc_d = d && (rob_q.size() < ROB_SIZE);
        acc_r = r && (rob_q.size() > 0);
        // oldest record leaves first
        if (acc_r) begin
            head         = rob_q.pop_front();
            c.areg       = head.areg;
            c.new_preg   = head.new_preg;
            c.freed_preg = head.old_preg;
            c.free_en    = (head.areg != '0);
            exp_commit   = c;
        end
        exp_commit_valid = acc_r;
        if (acc_d) begin
            res.rob_idx   = model_tail;
            res.src1_preg = map_m[i.i_view.rs1];
            res.src2_used = (i.r_view.opcode == OPCODE_OP);
            res.src2_preg = res.src2_used ? map_m[i.r_view.rs2] : '0;
            e.areg        = i.r_view.rd;
            // x0 is never renamed
            if (i.r_view.rd == '0) begin
                e.new_preg = '0;
                e.old_preg = '0;
            end else begin
                e.new_preg = free_q.pop_front();
                e.old_preg = map_m[i.r_view.rd];
                map_m[i.r_view.rd] = e.new_preg;
            end
            res.dest_preg = e.new_preg;
            rob_q.push_back(e);
            model_tail = model_tail + 1'b1;
            exp_rename = res;
        end
        exp_rename_valid = acc_d;
        // freed told queues behind the remaining pool
        if (acc_r && c.free_en) begin
            free_q.push_back(c.freed_preg);
        end
    endtask

    task automatic run_test(string name, int cycles, int disp_pct, int ret_pct, int zero_pct);
        test_errors = 0;
        test_num++;
        for (int n = 0; n < cycles; n++) begin
            step(chance(disp_pct), rand_inst(zero_pct), chance(ret_pct));
        end
        $display("test %0d %s: %0d cycles, %0d errors", test_num, name, cycles, test_errors);
    endtask

    initial begin
        reset    = 1'b1;
        dispatch = 1'b0;
        inst     = '0;
        retire   = 1'b0;
        checks   = 0;
        errors   = 0;
        test_num = 0;
        exp_rename_valid = 1'b0;
        exp_commit_valid = 1'b0;
        model_tail       = '0;
        // identity map and ascending pool out of reset
        for (int a = 0; a < NUM_AREG; a++) begin
            map_m[a] = preg_t'(a);
        end
        for (int p = NUM_AREG; p < NUM_PREG; p++) begin
            free_q.push_back(preg_t'(p));
        end
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        run_test("first_renames_from_pool", 12, 100, 0, 0);
        run_test("newest_mapping_and_src2", 200, 60, 55, 12);
        run_test("rd_zero_not_renamed", 100, 60, 60, 50);
        run_test("in_order_retire_reuse", 400, 55, 55, 12);
        run_test("fill_to_full", 24, 100, 0, 12);
        run_test("drain_to_empty", 24, 0, 100, 12);
        run_test("half_fill", 8, 100, 0, 12);
        run_test("dispatch_retire_overlap", 60, 100, 100, 12);
        run_test("final_drain", 24, 0, 100, 12);

        // flush the last expectations
        step(1'b0, '0, 1'b0);
        step(1'b0, '0, 1'b0);

        errors += dut.u_checker.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, checks, errors, dut.u_checker.fail_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rob_entry.sv
verilog/rob_dispatch.sv
verilog/rob_retire.sv
verilog/rename_rob_top.sv
tb/rename_rob_checker.sv
tb/rename_rob_tb.sv

/* Bender.yml */
package:
  name: rename_rob

sources:
  - files:
      - verilog/rename_pkg.sv
      - verilog/free_list.sv
      - verilog/map_table.sv
      - verilog/rob_entry.sv
      - verilog/rob_dispatch.sv
      - verilog/rob_retire.sv
      - verilog/rename_rob_top.sv
  - target: test
    files:
      - tb/rename_rob_checker.sv
      - tb/rename_rob_tb.sv
